//--- build.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module routerOutputPort_tb -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/VrouterOutputPort_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

//--- logic/flitMux.sv
`timescale 1ns/1ps

module flitMux
(
  input logic clk,
  input logic rst,
  input logic [routerPkg::stateWidth-1:0] grant,
  input logic [routerPkg::numPorts-1:0] req,
  input routerPkg::flitWord word [routerPkg::numPorts],
  output logic outValid,
  output logic [routerPkg::wordWidth-1:0] outWord
);

  logic [routerPkg::wordWidth-1:0] selWord;
  logic selValid;

  // AND-OR select on the one-hot grant. The idle bit selects nothing, so valid drops.
  always_comb
  begin
    selWord = '0;
    selValid = 1'b0;
    for (int p = 0; p < routerPkg::numPorts; p++)
    begin
      if (grant[p + 1])
      begin
        selWord = selWord | word[p].payload;
        selValid = selValid | req[p];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outWord <= '0;
    end
    else
    begin
      outValid <= selValid;
      outWord <= selWord;
    end
  end

endmodule

//--- logic/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter
(
  input logic clk,
  input logic rst,
  input logic [routerPkg::numPorts-1:0] req,
  input logic [routerPkg::flitIdWidth-1:0] flitId [routerPkg::numPorts],
  input routerPkg::flitWord word [routerPkg::numPorts],
  output logic [routerPkg::stateWidth-1:0] grant
);

  logic [routerPkg::stateWidth-1:0] nextGrant;
  logic [routerPkg::numPorts-1:0] runTimer;
  logic [routerPkg::numPorts-1:0] timesUp;
  logic [routerPkg::portIdxWidth-1:0] holder;
  logic held;

  timerLink link [routerPkg::numPorts] ();

  for (genvar p = 0; p < routerPkg::numPorts; p++)
  begin : portGen
    assign link[p].flitId = flitId[p];
    assign link[p].length = word[p].header.length;
    assign link[p].runTimer = runTimer[p];
    assign timesUp[p] = link[p].timesUp;

    packetTimer i_timer
    (
      .clk(clk),
      .rst(rst),
      .link(link[p])
    );
  end

  function automatic logic [routerPkg::stateWidth-1:0] portState(input int p);
    case (p)
      0: return routerPkg::stateL;
      1: return routerPkg::stateN;
      2: return routerPkg::stateE;
      3: return routerPkg::stateW;
      4: return routerPkg::stateS;
      default: return routerPkg::stateIdle;
    endcase
  endfunction

  // Returns the state of the first requesting port among span ports starting at start,
  // wrapping after S. The scan runs backwards so the nearest requester is written last.
  function automatic logic [routerPkg::stateWidth-1:0] firstRequest(
    input logic [routerPkg::numPorts-1:0] reqs,
    input int start,
    input int span
  );
    logic [2*routerPkg::numPorts-1:0] wrapped;
    logic [routerPkg::stateWidth-1:0] result;
    int idx;
    wrapped = {reqs, reqs};
    result = routerPkg::stateIdle;
    for (int k = routerPkg::numPorts - 1; k >= 0; k--)
    begin
      idx = start + k;
      if (k < span && wrapped[idx])
      begin
        if (idx >= routerPkg::numPorts)
        begin
          idx = idx - routerPkg::numPorts;
        end
        result = portState(idx);
      end
    end
    return result;
  endfunction

  // Decode the one-hot grant back to the index of the port holding it.
  always_comb
  begin
    holder = '0;
    held = 1'b0;
    for (int p = 0; p < routerPkg::numPorts; p++)
    begin
      if (grant[p + 1])
      begin
        holder = routerPkg::portIdxWidth'(p);
        held = 1'b1;
      end
    end
  end

  always_comb
  begin
    runTimer = '0;
    if (!held)
    begin
      // From idle the search starts at L, which gives the fixed L, N, E, W, S priority.
      nextGrant = firstRequest(req, 0, routerPkg::numPorts);
    end
    else if (req[holder] && !timesUp[holder])
    begin
      runTimer[holder] = 1'b1;
      nextGrant = grant;
    end
    else
    begin
      // The holder itself is skipped, so a port timed out with others waiting must yield.
      nextGrant = firstRequest(req, int'(holder) + 1, routerPkg::numPorts - 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= routerPkg::stateIdle;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

endmodule

//--- logic/packetTimer.sv
`timescale 1ns/1ps

module packetTimer
(
  input logic clk,
  input logic rst,
  timerLink.timer link
);

  logic [routerPkg::lengthWidth-1:0] limit;
  logic [routerPkg::lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // Every header flit on this input reloads the limit, whether it holds the grant or not.
      if (link.flitId == routerPkg::flitIdHeader)
      begin
        limit <= link.length;
      end

      // The count only survives while the grant is being kept.
      if (link.runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  // A grant started from a cleared count therefore lasts limit+1 cycles.
  assign link.timesUp = (count == limit);

endmodule

//--- logic/routerOutputPort.sv
`timescale 1ns/1ps

module routerOutputPort
(
  input logic clk,
  input logic rst,
  input logic [routerPkg::numPorts-1:0] req,
  input logic [routerPkg::numPorts-1:0][routerPkg::flitIdWidth-1:0] flitId,
  input logic [routerPkg::numPorts-1:0][routerPkg::wordWidth-1:0] word,
  output logic [routerPkg::stateWidth-1:0] grant,
  output logic outValid,
  output logic [routerPkg::wordWidth-1:0] outWord
);

  logic [routerPkg::flitIdWidth-1:0] flitIdList [routerPkg::numPorts];
  routerPkg::flitWord wordList [routerPkg::numPorts];

  // Each packed word port is viewed as a flit so that its header fields can be decoded.
  for (genvar p = 0; p < routerPkg::numPorts; p++)
  begin : unpackGen
    assign flitIdList[p] = flitId[p];
    assign wordList[p] = routerPkg::flitWord'(word[p]);
  end

  outputArbiter i_arbiter
  (
    .clk(clk),
    .rst(rst),
    .req(req),
    .flitId(flitIdList),
    .word(wordList),
    .grant(grant)
  );

  flitMux i_mux
  (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .req(req),
    .word(wordList),
    .outValid(outValid),
    .outWord(outWord)
  );

endmodule

//--- logic/routerPkg.sv
package routerPkg;

  // Port order everywhere is L, N, E, W, S at indices 0 to 4.
  localparam int numPorts = 5;
  localparam int portIdxWidth = $clog2(numPorts);

  localparam int wordWidth = 16;
  localparam int lengthWidth = 12;
  localparam int routeWidth = wordWidth - lengthWidth;
  localparam int flitIdWidth = 3;

  localparam logic [flitIdWidth-1:0] flitIdHeader = 3'd1;

  // One-hot grant state. Bit 0 is idle, bits 1 to 5 follow the port order.
  localparam int stateWidth = numPorts + 1;

  localparam logic [stateWidth-1:0] stateIdle = 6'b000001;
  localparam logic [stateWidth-1:0] stateL = 6'b000010;
  localparam logic [stateWidth-1:0] stateN = 6'b000100;
  localparam logic [stateWidth-1:0] stateE = 6'b001000;
  localparam logic [stateWidth-1:0] stateW = 6'b010000;
  localparam logic [stateWidth-1:0] stateS = 6'b100000;

  // Header flit layout. The length field bounds how long the packet may hold an output.
  typedef struct packed {
    logic [routeWidth-1:0] route;
    logic [lengthWidth-1:0] length;
  } flitHeader;

  // A flit word is read as a header by the arbiter and forwarded raw by the mux.
  typedef union packed {
    flitHeader header;
    logic [wordWidth-1:0] payload;
  } flitWord;

endpackage

//--- logic/timerLink.sv
`timescale 1ns/1ps

interface timerLink;

  logic [routerPkg::flitIdWidth-1:0] flitId;
  logic [routerPkg::lengthWidth-1:0] length;
  logic runTimer;
  logic timesUp;

  modport arbiter (
    output flitId,
    output length,
    output runTimer,
    input timesUp
  );

  modport timer (
    input flitId,
    input length,
    input runTimer,
    output timesUp
  );

endinterface

//--- test/routerOutputPort_assert.sv
`timescale 1ns/1ps

module routerOutputPort_assert
(
  input logic clk,
  input logic rst,
  input logic [routerPkg::numPorts-1:0] req,
  input logic [routerPkg::stateWidth-1:0] grant
);

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("grant %b is not one-hot", grant);

  resetToIdle: assert property (@(posedge clk) rst |=> grant == routerPkg::stateIdle)
    else $error("grant did not return to idle after reset");

  for (genvar p = 0; p < routerPkg::numPorts; p++)
  begin : releaseGen
    // A holder whose request has fallen is gone at the next edge.
    releaseOnDrop: assert property (@(posedge clk) disable iff (rst)
      (grant[p + 1] && !req[p]) |=> !grant[p + 1])
      else $error("grant stayed on port %0d after its request fell", p);
  end

endmodule

bind outputArbiter routerOutputPort_assert i_assert
(
  .clk(clk),
  .rst(rst),
  .req(req),
  .grant(grant)
);

//--- test/routerOutputPort_tb.sv
`timescale 1ns/1ps

module routerOutputPort_tb;

  logic clk;
  logic rst;
  logic [routerPkg::numPorts-1:0] req;
  logic [routerPkg::numPorts-1:0][routerPkg::flitIdWidth-1:0] flitId;
  logic [routerPkg::numPorts-1:0][routerPkg::wordWidth-1:0] word;
  logic [routerPkg::stateWidth-1:0] grant;
  logic outValid;
  logic [routerPkg::wordWidth-1:0] outWord;

  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  // Far above the hundred or so cycles that all tests take together.
  int cycleLimit = 2000;
  logic [31:0] lcgState;

  tbClock i_clock (.*);

  routerOutputPort i_dut (.*);

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("[ERROR] time %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    end
  endtask

  // Requests change on one edge and the grant follows on the next.
  task applyRequests(input logic [routerPkg::numPorts-1:0] reqs,
                     input logic [routerPkg::stateWidth-1:0] expected);
    @(posedge clk);
    req <= reqs;
    @(posedge clk);
    @(negedge clk);
    checkValue("grant", 32'(expected), 32'(grant));
  endtask

  task releaseAll();
    @(posedge clk);
    req <= '0;
    flitId <= '0;
    @(posedge clk);
    @(negedge clk);
    checkValue("grant", 32'(routerPkg::stateIdle), 32'(grant));
  endtask

  // Puts a header flit with the given length on the chosen ports for one cycle.
  task loadLimits(input logic [routerPkg::numPorts-1:0] ports, input logic [11:0] limit);
    logic [routerPkg::numPorts-1:0][routerPkg::flitIdWidth-1:0] ids;
    for (int p = 0; p < routerPkg::numPorts; p++)
    begin
      ids[p] = ports[p] ? routerPkg::flitIdHeader : 3'd0;
    end
    @(posedge clk);
    flitId <= ids;
    word <= {routerPkg::numPorts{4'h9, limit}};
    @(posedge clk);
    flitId <= '0;
  endtask

  task testResetIdle();
    @(negedge clk);
    checkValue("grant", 32'(routerPkg::stateIdle), 32'(grant));
    checkValue("outValid", 32'd0, 32'(outValid));
  endtask

  task testIdlePriority();
    logic [routerPkg::numPorts-1:0] subsets [6];
    logic [routerPkg::stateWidth-1:0] winners [6];
    subsets = '{5'b11010, 5'b10100, 5'b11111, 5'b10000, 5'b11000, 5'b01100};
    winners = '{routerPkg::stateN, routerPkg::stateE, routerPkg::stateL, routerPkg::stateS,
                routerPkg::stateW, routerPkg::stateE};
    for (int i = 0; i < 6; i++)
    begin
      applyRequests(subsets[i], winners[i]);
      releaseAll();
    end
  endtask

  task testTimeLimit();
    logic [31:0] r;
    int n;
    int held;
    r = nextRandom();
    n = 3 + int'(r[18:16]);
    loadLimits(5'b00100, 12'(n));
    applyRequests(5'b01100, routerPkg::stateE);
    // Count the cycles that E keeps the grant while its request stays high.
    held = 0;
    while (grant == routerPkg::stateE && held < 20)
    begin
      held++;
      @(negedge clk);
    end
    checkValue("cycles granted to E", 32'(n + 1), 32'(held));
    checkValue("grant", 32'(routerPkg::stateW), 32'(grant));
    releaseAll();
  endtask

  task testCyclicOrder();
    logic [routerPkg::stateWidth-1:0] order [5];
    order = '{routerPkg::stateN, routerPkg::stateE, routerPkg::stateW, routerPkg::stateS,
              routerPkg::stateL};
    // With a zero limit every holder yields after a single cycle.
    loadLimits('1, 12'd0);
    applyRequests('1, routerPkg::stateL);
    for (int i = 0; i < 5; i++)
    begin
      @(negedge clk);
      checkValue("grant", 32'(order[i]), 32'(grant));
    end
    releaseAll();
    // A long limit keeps the holder, so only a dropped request moves the grant.
    loadLimits('1, 12'd15);
    applyRequests('1, routerPkg::stateL);
    applyRequests(5'b11100, routerPkg::stateE);
    applyRequests(5'b11000, routerPkg::stateW);
    applyRequests(5'b10001, routerPkg::stateS);
    applyRequests(5'b00001, routerPkg::stateL);
    releaseAll();
  endtask

  task testForwarding();
    logic [31:0] r;
    logic [routerPkg::wordWidth-1:0] sentWord;
    loadLimits(5'b00010, 12'd40);
    r = nextRandom();
    sentWord = r[31:16];
    @(posedge clk);
    req <= 5'b00010;
    word[1] <= sentWord;
    @(posedge clk);
    @(negedge clk);
    // The mux still saw the idle grant at this edge.
    checkValue("grant", 32'(routerPkg::stateN), 32'(grant));
    checkValue("outValid", 32'd0, 32'(outValid));
    for (int k = 0; k < 16; k++)
    begin
      @(posedge clk);
      r = nextRandom();
      word[0] <= r[15:0];
      word[1] <= r[31:16];
      word[2] <= ~r[31:16];
      @(negedge clk);
      checkValue("outWord", 32'(sentWord), 32'(outWord));
      checkValue("outValid", 32'd1, 32'(outValid));
      sentWord = r[31:16];
    end
    @(posedge clk);
    req <= '0;
    @(negedge clk);
    checkValue("outWord", 32'(sentWord), 32'(outWord));
    @(negedge clk);
    checkValue("grant", 32'(routerPkg::stateIdle), 32'(grant));
    checkValue("outValid", 32'd0, 32'(outValid));
    @(negedge clk);
    checkValue("outValid", 32'd0, 32'(outValid));
  endtask

  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout: the tests did not finish within %0d clock cycles", cycleLimit);
      $display("Test FAILED");
      $finish;
    end
  end

  initial
  begin
    req = '0;
    flitId = '0;
    word = '0;
    lcgState = 32'h7124_11f6;
    @(negedge clk);
    while (rst !== 1'b0)
    begin
      @(negedge clk);
    end
    testResetIdle();
    testIdlePriority();
    testTimeLimit();
    testCyclicOrder();
    testForwarding();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- test/tbClock.sv
`timescale 1ns/1ps

module tbClock
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #20 clk = ~clk;
    end
  end

  // Reset is held over the first four rising edges.
  initial
  begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- verilog.f
logic/routerPkg.sv
logic/timerLink.sv
logic/packetTimer.sv
logic/outputArbiter.sv
logic/flitMux.sv
logic/routerOutputPort.sv
test/tbClock.sv
test/routerOutputPort_assert.sv
test/routerOutputPort_tb.sv
